/* hdl/rsPkg.sv */
`default_nettype none

// ============================================================
// Reservation station dispatch side, shared definitions
// ============================================================

package rsPkg;

  localparam int RS_COUNT = 8; // number of reservation-station entries.
  localparam int LANES = 3; // micro-ops offered per dispatch group.
  localparam int TAG_W = 6; // width of the micro-op tag.

  // wide enough to hold the value RS_COUNT itself, not just an index.
  localparam int OCC_W = $clog2(RS_COUNT + 1);

  // ============================================================
  // Micro-op and dispatch group
  // ============================================================

  typedef enum logic [1:0] {
    OP_ALU   = 2'd0, // integer arithmetic.
    OP_MUL   = 2'd1, // multiply unit.
    OP_LOAD  = 2'd2, // memory read.
    OP_STORE = 2'd3  // memory write.
  } rsOp_e;

  typedef struct packed {
    rsOp_e op; // what the entry will execute.
    logic [TAG_W-1:0] tag; // rename tag of the result.
  } rsUop_t;

  // Lane n of the group is uops[n] and is valid when mask[n] is set.
  typedef struct packed {
    logic [LANES-1:0] mask; // one bit per lane that carries a micro-op.
    rsUop_t [LANES-1:0] uops; // the micro-ops, indexed by lane.
  } dispGroup_t;

  // ============================================================
  // Dispatch handshake states
  // ============================================================

  typedef enum logic [1:0] {
    DS_IDLE      = 2'd0, // waiting for a request that fits.
    DS_ACK       = 2'd1, // group written, ack held until req drops.
    DS_WAIT_DROP = 2'd2  // ack dropped, one cycle before the next group.
  } dispState_e;

endpackage

`default_nettype wire

/* hdl/rsAlloc.sv */
`timescale 1ns/10ps
`default_nettype none

// Picks free entries for the three dispatch lanes in a single cycle.
module rsAlloc import rsPkg::*; (
  input  wire logic [RS_COUNT-1:0] freeVec,
  input  wire logic [LANES-1:0]    mask,
  output logic      [RS_COUNT-1:0] sel0,
  output logic      [RS_COUNT-1:0] sel1,
  output logic      [RS_COUNT-1:0] sel2,
  output logic                     stall
);

  // ============================================================
  // Priority pickers
  // ============================================================

  function automatic logic [RS_COUNT-1:0] findFirst(input logic [RS_COUNT-1:0] vec);
    logic [RS_COUNT-1:0] hit;
    hit = '0;
    for (int i = RS_COUNT - 1; i >= 0; i--) begin
      if (vec[i]) begin
        hit = '0; // a lower free bit overrides any higher one.
        hit[i] = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic [RS_COUNT-1:0] findLast(input logic [RS_COUNT-1:0] vec);
    logic [RS_COUNT-1:0] hit;
    hit = '0;
    for (int i = 0; i < RS_COUNT; i++) begin
      if (vec[i]) begin
        hit = '0; // a higher free bit overrides any lower one.
        hit[i] = 1'b1;
      end
    end
    return hit;
  endfunction

  logic [RS_COUNT-1:0] first; // lowest free entry.
  logic [RS_COUNT-1:0] last; // highest free entry.
  logic [RS_COUNT-1:0] next; // lowest free entry left over by lane 0.
  logic lack0;
  logic lack1;
  logic lack2;

  assign first = findFirst(freeVec);
  assign last = findLast(freeVec);

  // Lane 2 skips lane 0's pick only when lane 0 actually dispatches, so
  // lanes 1 and 2 alone still fit into two free entries.
  assign next = findFirst(freeVec & ~(first & {RS_COUNT{mask[0]}}));

  // ============================================================
  // Stall decision
  // ============================================================

  assign lack0 = mask[0] && (first == '0); // nothing free at all.
  assign lack1 = mask[1] && ((last == '0) || (mask[0] && (first == last)));
  assign lack2 = mask[2] && ((next == '0) || (mask[1] && (next == last)));

  // Any lane short of a distinct entry means the group needs more entries than are free.
  assign stall = lack0 | lack1 | lack2;

  assign sel0 = first & {RS_COUNT{mask[0]}}; // unused lanes select nothing.
  assign sel1 = last & {RS_COUNT{mask[1]}};
  assign sel2 = next & {RS_COUNT{mask[2]}};

endmodule

`default_nettype wire

/* hdl/rsEntryTable.sv */
`timescale 1ns/10ps
`default_nettype none

// Holds the reservation-station entries and issues them one at a time.
module rsEntryTable import rsPkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                writeEn,
  input  wire logic [RS_COUNT-1:0] sel0,
  input  wire logic [RS_COUNT-1:0] sel1,
  input  wire logic [RS_COUNT-1:0] sel2,
  input  wire dispGroup_t          dispGroup,
  output logic      [RS_COUNT-1:0] validVec,
  output logic                     issueReq,
  output rsUop_t                   issueUop,
  input  wire logic                issueAck,
  output logic                     issueFree
);

  rsUop_t entries [RS_COUNT]; // payload storage, meaningful only where valid.

  logic [RS_COUNT-1:0] issueSel; // one-hot entry being offered on the issue port.
  logic [RS_COUNT-1:0] lowValid; // one-hot lowest valid entry.
  logic [RS_COUNT-1:0] setMask;
  logic [RS_COUNT-1:0] clrMask;

  // ============================================================
  // Dispatch write
  // ============================================================

  // The selects are one-hot and mutually distinct, so one lane at most hits an entry.
  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_COUNT; i++) begin
      if (writeEn) begin
        if (sel0[i]) begin
          entries[i] <= dispGroup.uops[0];
        end else if (sel1[i]) begin
          entries[i] <= dispGroup.uops[1];
        end else if (sel2[i]) begin
          entries[i] <= dispGroup.uops[2];
        end
      end
    end
  end

  assign setMask = writeEn ? (sel0 | sel1 | sel2) : '0; // entries claimed this cycle.
  assign clrMask = issueFree ? issueSel : '0; // entry handed to the consumer.

  // ============================================================
  // Issue handshake
  // ============================================================

  // Two's complement trick isolates the lowest set bit of the valid vector.
  assign lowValid = validVec & (~validVec + 1'b1);

  // The entry is released on the first cycle the consumer acknowledges.
  assign issueFree = issueReq & issueAck;

  always_ff @(posedge clk) begin
    if (rst) begin
      validVec <= '0;
      issueReq <= 1'b0;
      issueSel <= '0;
    end else begin
      validVec <= (validVec | setMask) & ~clrMask;
      if (issueFree) begin
        issueReq <= 1'b0; // req falls once the ack has been seen.
      end else if (!issueReq && !issueAck && (validVec != '0)) begin
        issueReq <= 1'b1; // a new offer waits for the previous ack to drop.
        issueSel <= lowValid;
      end
    end
  end

  // Offered entry stays valid and unwritten until freed, so this mux is stable.
  always_comb begin
    issueUop = '0;
    for (int i = 0; i < RS_COUNT; i++) begin
      if (issueSel[i]) begin
        issueUop = entries[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rsDispatchCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

// Runs the four-phase dispatch handshake and times the group write.
module rsDispatchCtrl import rsPkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic dispReq,
  input  wire logic stall,
  output logic      dispAck,
  output logic      writeEn
);

  dispState_e state;
  dispState_e nextState;

  // ============================================================
  // Next-state logic
  // ============================================================

  always_comb begin
    nextState = state;
    writeEn = 1'b0;
    case (state)
      DS_IDLE: begin
        // A request that does not fit just sits here until issues free room.
        if (dispReq && !stall) begin
          writeEn = 1'b1; // whole group goes in on this edge.
          nextState = DS_ACK;
        end
      end
      DS_ACK: begin
        if (!dispReq) begin
          nextState = DS_WAIT_DROP; // front end has seen the ack.
        end
      end
      DS_WAIT_DROP: begin
        nextState = DS_IDLE; // ack is low for this cycle.
      end
      default: begin
        nextState = DS_IDLE;
      end
    endcase
  end

  // ============================================================
  // State register
  // ============================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= DS_IDLE;
    end else begin
      state <= nextState;
    end
  end

  // Ack is a pure function of the state, so it rises the cycle after writeEn.
  assign dispAck = (state == DS_ACK);

endmodule

`default_nettype wire

/* hdl/rsOccupancyCounter.sv */
`timescale 1ns/10ps
`default_nettype none

// Tracks how many reservation-station entries are held.
module rsOccupancyCounter import rsPkg::*; (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             writeEn,
  input  wire logic [LANES-1:0] mask,
  input  wire logic             issueFree,
  output logic      [OCC_W-1:0] occupancy
);

  logic [OCC_W-1:0] laneCount; // lanes written by the current group.
  logic [OCC_W-1:0] addCount;
  logic [OCC_W-1:0] subCount;

  // ============================================================
  // Increment and decrement terms
  // ============================================================

  always_comb begin
    laneCount = '0;
    for (int i = 0; i < LANES; i++) begin
      laneCount = laneCount + {{(OCC_W - 1){1'b0}}, mask[i]}; // population count.
    end
  end

  assign addCount = writeEn ? laneCount : '0;
  assign subCount = {{(OCC_W - 1){1'b0}}, issueFree}; // one entry leaves per issue.

  // A write and a free may land on the same edge; both apply.
  always_ff @(posedge clk) begin
    if (rst) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + addCount - subCount;
    end
  end

endmodule

`default_nettype wire

/* hdl/rsDispatchTop.sv */
`timescale 1ns/10ps
`default_nettype none

// Dispatch-side slot allocator of the reservation station.
module rsDispatchTop import rsPkg::*; (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             dispReq,
  input  wire dispGroup_t       dispGroup,
  output logic                  dispAck,
  output logic                  issueReq,
  output rsUop_t                issueUop,
  input  wire logic             issueAck,
  output logic      [OCC_W-1:0] occupancy
);

  logic [RS_COUNT-1:0] validVec; // entries currently held.
  logic [RS_COUNT-1:0] sel0;
  logic [RS_COUNT-1:0] sel1;
  logic [RS_COUNT-1:0] sel2;
  logic stall;
  logic writeEn;
  logic issueFree;

  // ============================================================
  // Allocation and dispatch
  // ============================================================

  rsAlloc alloc_i (
    .freeVec (~validVec),
    .mask    (dispGroup.mask),
    .sel0    (sel0),
    .sel1    (sel1),
    .sel2    (sel2),
    .stall   (stall)
  );

  rsDispatchCtrl ctrl_i (
    .clk     (clk),
    .rst     (rst),
    .dispReq (dispReq),
    .stall   (stall),
    .dispAck (dispAck),
    .writeEn (writeEn)
  );

  // ============================================================
  // Storage, issue and occupancy
  // ============================================================

  rsEntryTable table_i (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (writeEn),
    .sel0      (sel0),
    .sel1      (sel1),
    .sel2      (sel2),
    .dispGroup (dispGroup),
    .validVec  (validVec),
    .issueReq  (issueReq),
    .issueUop  (issueUop),
    .issueAck  (issueAck),
    .issueFree (issueFree)
  );

  rsOccupancyCounter occ_i (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (writeEn),
    .mask      (dispGroup.mask),
    .issueFree (issueFree),
    .occupancy (occupancy)
  );

endmodule

`default_nettype wire

/* tests/rsDispatchTb_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// Handshake rules watched on the top level of the dispatch block.
module rsDispatchTb_properties import rsPkg::*; (
  input wire logic             clk,
  input wire logic             rst,
  input wire logic             dispReq,
  input wire logic             dispAck,
  input wire logic             issueReq,
  input wire rsUop_t           issueUop,
  input wire logic             issueAck,
  input wire logic [OCC_W-1:0] occupancy
);

  int violations = 0; // failed property count.

  ackNeedsReq: assert property (@(posedge clk) disable iff (rst) $rose(dispAck) |-> dispReq)
    else begin
      $error("dispAck rose while dispReq was low");
      violations++;
    end

  // an offer may only be withdrawn once the consumer has acknowledged it.
  reqHoldsUntilAck: assert property (@(posedge clk) disable iff (rst)
    issueReq && !issueAck |=> issueReq)
    else begin
      $error("issueReq dropped before issueAck");
      violations++;
    end

  uopStable: assert property (@(posedge clk) disable iff (rst)
    issueReq |=> !issueReq || $stable(issueUop))
    else begin
      $error("issueUop changed while issueReq was high");
      violations++;
    end

  occBounded: assert property (@(posedge clk) disable iff (rst) occupancy <= OCC_W'(RS_COUNT))
    else begin
      $error("occupancy exceeded the entry count");
      violations++;
    end

endmodule

bind rsDispatchTop rsDispatchTb_properties props_i (
  .clk       (clk),
  .rst       (rst),
  .dispReq   (dispReq),
  .dispAck   (dispAck),
  .issueReq  (issueReq),
  .issueUop  (issueUop),
  .issueAck  (issueAck),
  .occupancy (occupancy)
);

`default_nettype wire

/* tests/rsDispatchTb.sv */
`timescale 1ns/10ps
`default_nettype none

module rsDispatchTb import rsPkg::*; ();

  // arg is the stall issue count for D, hold cycles for I, occupancy for O.
  typedef struct packed {
    logic [7:0] kind;
    logic [LANES-1:0] mask;
    rsUop_t [LANES-1:0] uops;
    logic [15:0] arg;
  } testCmd_t;

  logic clk;
  logic rst;
  logic dispReq;
  dispGroup_t dispGroup;
  logic dispAck;
  logic issueReq;
  rsUop_t issueUop;
  logic issueAck;
  logic [OCC_W-1:0] occupancy;

  testCmd_t cmds[$];
  logic [RS_COUNT-1:0] modelValid; // reference copy of the valid vector.
  rsUop_t modelUop [RS_COUNT];
  int offerIdx; // entry the DUT offers next, -1 while nothing is offered.
  int cycleCount = 0;
  int cycleLimit = 0;

  rsDispatchTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .dispReq   (dispReq),
    .dispGroup (dispGroup),
    .dispAck   (dispAck),
    .issueReq  (issueReq),
    .issueUop  (issueUop),
    .issueAck  (issueAck),
    .occupancy (occupancy)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      abortRun("timed out before the test list finished");
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string what);
    abortRun($sformatf("** Error at %0t ns: %s", $time, what));
  endtask

  // ============================================================
  // Reference model
  // ============================================================

  function automatic int lowestIndex(input logic [RS_COUNT-1:0] vec);
    int idx;
    idx = -1;
    for (int i = 0; i < RS_COUNT; i++) begin
      if (vec[i] && idx < 0) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Lane 0 first free, lane 1 last free, lane 2 first free other than lane 0's.
  function automatic bit pickSlots(input logic [LANES-1:0] mask,
                                   input logic [RS_COUNT-1:0] valid, output int slot [LANES]);
    int freeList[$];
    slot = '{default: -1};
    for (int i = 0; i < RS_COUNT; i++) begin
      if (!valid[i]) begin
        freeList.push_back(i);
      end
    end
    if (mask[0]) begin
      if (freeList.size() == 0) return 1'b0;
      slot[0] = freeList[0];
    end
    if (mask[1]) begin
      if (freeList.size() == 0 || freeList[$] == slot[0]) return 1'b0;
      slot[1] = freeList[$];
    end
    if (mask[2]) begin
      foreach (freeList[k]) begin
        if (freeList[k] != slot[0] && slot[2] < 0) slot[2] = freeList[k];
      end
      if (slot[2] < 0 || slot[2] == slot[1]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // ============================================================
  // Handshake tasks
  // ============================================================

  task automatic issueOne(input rsUop_t expUop, input int hold);
    rsUop_t held;
    logic [OCC_W-1:0] heldOcc;
    while (!issueReq) @(posedge clk);
    assert (offerIdx >= 0 && modelUop[offerIdx] == expUop) else reportMismatch($sformatf(
      "test file expects op %0d tag %h, model disagrees", expUop.op, expUop.tag));
    assert (issueUop == expUop) else reportMismatch($sformatf(
      "issued op %0d tag %h, expected op %0d tag %h", issueUop.op, issueUop.tag,
      expUop.op, expUop.tag));
    held = issueUop;
    heldOcc = occupancy;
    repeat (hold) begin
      @(posedge clk);
      assert (issueReq && issueUop == held && occupancy == heldOcc)
        else reportMismatch("issue offer changed or an entry was freed without an ack");
    end
    issueAck <= 1'b1;
    do begin
      @(posedge clk);
    end while (issueReq);
    issueAck <= 1'b0;
    modelValid[offerIdx] = 1'b0;
    offerIdx = lowestIndex(modelValid); // next offer latches before any later write.
  endtask

  task automatic runDispatch(input testCmd_t c);
    int slot [LANES];
    bit fits;
    int frees;
    int waited;
    frees = 0;
    waited = 0;
    fits = pickSlots(c.mask, modelValid, slot);
    assert (fits == (c.arg == 0)) else reportMismatch($sformatf(
      "test file stall count %0d disagrees with model fit %0b", c.arg, fits));
    dispGroup.mask <= c.mask;
    dispGroup.uops <= c.uops;
    dispReq <= 1'b1;
    if (!fits) begin
      repeat (8) begin
        @(posedge clk);
        assert (!dispAck) else reportMismatch("dispAck rose for a group that does not fit");
      end
      while (!fits) begin
        issueOne(modelUop[offerIdx], 0);
        frees++;
        fits = pickSlots(c.mask, modelValid, slot);
      end
      assert (frees == c.arg) else reportMismatch($sformatf(
        "group fits after %0d issues, test file says %0d", frees, c.arg));
    end
    do begin
      @(posedge clk);
      waited++;
    end while (!dispAck);
    assert (frees > 0 || waited == 2) else reportMismatch($sformatf(
      "dispAck after %0d cycles, expected 2", waited));
    dispReq <= 1'b0;
    for (int l = 0; l < LANES; l++) begin
      if (c.mask[l]) begin
        modelValid[slot[l]] = 1'b1;
        modelUop[slot[l]] = c.uops[l];
      end
    end
    if (frees > 0 || offerIdx < 0) begin
      offerIdx = lowestIndex(modelValid); // the offer latches after this write.
    end
    do begin
      @(posedge clk);
    end while (dispAck);
  endtask

  task automatic checkOccupancy(input int expOcc);
    assert ($countones(modelValid) == expOcc) else reportMismatch($sformatf(
      "test file occupancy %0d disagrees with model", expOcc));
    assert (occupancy == expOcc) else reportMismatch($sformatf(
      "occupancy %0d, expected %0d", occupancy, expOcc));
    if (modelValid == '0) begin
      repeat (3) begin
        @(posedge clk);
        assert (!issueReq) else reportMismatch("issueReq high with every entry empty");
      end
    end
  endtask

  task automatic loadTests();
    int fd;
    logic [7:0] kind;
    logic [31:0] v [8];
    logic [8*160-1:0] rest;
    testCmd_t c;
    fd = $fopen("tests/rsDispatch_tests.txt", "r");
    if (fd == 0) abortRun("could not open tests/rsDispatch_tests.txt");
    while ($fscanf(fd, " %c", kind) == 1) begin
      c = '0;
      c.kind = kind;
      if (kind == "#") begin
        void'($fgets(rest, fd));
      end else if (kind == "D") begin
        if ($fscanf(fd, "%h %h %h %h %h %h %h %d", v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                    v[7]) != 8) abortRun("malformed D line in the test file");
        c.mask = v[0][LANES-1:0];
        for (int l = 0; l < LANES; l++) begin
          c.uops[l] = {v[1 + 2 * l][1:0], v[2 + 2 * l][TAG_W-1:0]};
        end
        c.arg = v[7][15:0];
      end else if (kind == "I") begin
        if ($fscanf(fd, "%h %h %d", v[0], v[1], v[2]) != 3) abortRun("malformed I line");
        c.uops[0] = {v[0][1:0], v[1][TAG_W-1:0]};
        c.arg = v[2][15:0];
      end else if (kind == "O") begin
        if ($fscanf(fd, "%d", v[0]) != 1) abortRun("malformed O line in the test file");
        c.arg = v[0][15:0];
      end else begin
        abortRun($sformatf("unknown command %c in the test file", kind));
      end
      if (kind != "#") cmds.push_back(c);
    end
    $fclose(fd);
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    dispReq = 1'b0;
    dispGroup = '0;
    issueAck = 1'b0;
    modelValid = '0;
    offerIdx = -1;
    loadTests();
    cycleLimit = 50 * cmds.size() + 4; // reset cycles on top of the per-command budget.
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!dispAck && !issueReq) else reportMismatch("handshake outputs high after reset");
    foreach (cmds[n]) begin
      case (cmds[n].kind)
        "D": runDispatch(cmds[n]);
        "I": issueOne(cmds[n].uops[0], cmds[n].arg);
        default: checkOccupancy(cmds[n].arg);
      endcase
    end
    if (dut_i.props_i.violations == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abortRun($sformatf("%0d handshake property violations", dut_i.props_i.violations));
    end
  end

endmodule

`default_nettype wire

/* rsDispatchTop.f */
hdl/rsPkg.sv
hdl/rsAlloc.sv
hdl/rsEntryTable.sv
hdl/rsDispatchCtrl.sv
hdl/rsOccupancyCounter.sv
hdl/rsDispatchTop.sv
tests/rsDispatchTb_properties.sv
tests/rsDispatchTb.sv

/* Bender.yml */
package:
  name: rsDispatch

sources:
  - files:
      - hdl/rsPkg.sv
      - hdl/rsAlloc.sv
      - hdl/rsEntryTable.sv
      - hdl/rsDispatchCtrl.sv
      - hdl/rsOccupancyCounter.sv
      - hdl/rsDispatchTop.sv
  - target: test
    files:
      - tests/rsDispatchTb_properties.sv
      - tests/rsDispatchTb.sv

/* tests/rsDispatch_tests.txt */
# columns: D mask op0 tag0 op1 tag1 op2 tag2 stallIssues | I op tag holdCycles | O occupancy
# op 0 ALU, 1 MUL, 2 LOAD, 3 STORE; mask, op and tag in hex, last column decimal
O 0
D 1 0 01 0 00 0 00 0
O 1
D 7 1 02 2 03 3 04 0
O 4
I 0 01 0
I 1 02 0
I 3 04 0
I 2 03 0
O 0
# masks with gaps
D 5 0 10 0 00 1 11 0
O 2
D 6 0 00 2 12 3 13 0
O 4
D 2 0 00 1 14 0 00 0
O 5
# slow consumer holds the ack low
I 0 10 12
O 4
D 7 0 20 0 21 0 22 0
O 7
# one entry free, three needed, accepted after two issues
D 7 1 30 2 31 3 32 2
O 8
I 1 30 0
I 3 32 0
I 3 13 0
I 0 22 0
I 2 31 0
I 0 21 3
I 1 14 0
I 2 12 0
O 0
